//--- core_top_pkg.sv
////////////////////////////////////////////////////////////
// Core infrastructure package
// Widths, sizes, payload types and the reset-time scramble
// key and nonce shared by the core infrastructure blocks
////////////////////////////////////////////////////////////

`default_nettype none

package core_top_pkg;

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN        = 32;
  localparam int unsigned RF_NUM_REGS = 32;
  localparam int unsigned RF_ADDR_W   = 5;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [XLEN-1:0]      rf_data_t;

  ////////////////////////////////////////////////////////////
  // Instruction cache RAMs
  ////////////////////////////////////////////////////////////

  localparam int unsigned IC_NUM_WAYS  = 2;
  localparam int unsigned IC_NUM_LINES = 64;
  localparam int unsigned IC_INDEX_W   = 6;
  localparam int unsigned IC_TAG_W     = 22;
  localparam int unsigned IC_LINE_W    = 64;

  typedef logic [IC_INDEX_W-1:0] ic_index_t;
  typedef logic [IC_TAG_W-1:0]   ic_tag_t;
  typedef logic [IC_LINE_W-1:0]  ic_line_t;

  ////////////////////////////////////////////////////////////
  // Scrambling
  ////////////////////////////////////////////////////////////

  localparam int unsigned SCR_KEY_W   = 32;
  localparam int unsigned SCR_NONCE_W = 16;

  typedef logic [SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [SCR_NONCE_W-1:0] scr_nonce_t;

  // Key and nonce in use until the first key delivery
  localparam scr_key_t   RND_KEY_DEFAULT   = 32'h5a3c_96e1;
  localparam scr_nonce_t RND_NONCE_DEFAULT = 16'hc3a5;

endpackage

`default_nettype wire

//--- core_sleep_ctrl.sv
////////////////////////////////////////////////////////////
// Core sleep control
// Registers the core busy flag, forms the wake terms and
// gates the core clock, with a test enable override
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o,
  output logic clk_gated_o
);

  logic core_busy_q;
  logic clock_en;
  logic gate_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Wake terms act in the same cycle, busy one edge later
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////

  // Enable is transparent only while the clock is low
  always_latch begin
    if (!clk_i) begin
      gate_en_q <= clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & gate_en_q;

endmodule

`default_nettype wire

//--- register_file_ff.sv
////////////////////////////////////////////////////////////
// Flip-flop register file
// 32 entries, two combinational read ports and one write
// port, register zero hard-wired to zero
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module register_file_ff (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  core_top_pkg::rf_addr_t raddr_a_i,
  input  core_top_pkg::rf_addr_t raddr_b_i,
  input  core_top_pkg::rf_addr_t waddr_i,
  input  core_top_pkg::rf_data_t wdata_i,
  input  logic                  we_i,
  output core_top_pkg::rf_data_t rdata_a_o,
  output core_top_pkg::rf_data_t rdata_b_o
);

  logic [core_top_pkg::RF_NUM_REGS-1:1] we_dec;
  core_top_pkg::rf_data_t               rf_reg [core_top_pkg::RF_NUM_REGS];

  // Entry zero never stores anything
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < core_top_pkg::RF_NUM_REGS; i++) begin : gen_regs
    assign we_dec[i] = we_i && (waddr_i == core_top_pkg::rf_addr_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= wdata_i;
      end
    end
  end

  // Read multiplexers
  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

`default_nettype wire

//--- scramble_key_mgr.sv
////////////////////////////////////////////////////////////
// Instruction cache scramble key manager
// Requests a fresh key after a cache invalidate and holds
// the key and nonce used by the scrambled RAM banks
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module scramble_key_mgr (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    icache_inval_i,
  input  logic                    scramble_key_valid_i,
  input  core_top_pkg::scr_key_t   scramble_key_i,
  input  core_top_pkg::scr_nonce_t scramble_nonce_i,
  output logic                    scramble_req_o,
  output logic                    key_valid_o,
  output core_top_pkg::scr_key_t   key_o,
  output core_top_pkg::scr_nonce_t nonce_o
);

  logic                    scramble_req_d, scramble_req_q;
  logic                    key_valid_d, key_valid_q;
  core_top_pkg::scr_key_t   key_q;
  core_top_pkg::scr_nonce_t nonce_q;

  ////////////////////////////////////////////////////////////
  // Request and valid state
  ////////////////////////////////////////////////////////////

  // Request opens on invalidate and closes with a delivered key
  assign scramble_req_d = scramble_req_q ? ~scramble_key_valid_i : icache_inval_i;

  // Key goes invalid on invalidate, valid again on delivery
  assign key_valid_d = scramble_req_q ? scramble_key_valid_i :
                       icache_inval_i ? 1'b0                 :
                                        key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scramble_req_q <= 1'b0;
      key_valid_q    <= 1'b1;
    end else begin
      scramble_req_q <= scramble_req_d;
      key_valid_q    <= key_valid_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Key and nonce registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= core_top_pkg::RND_KEY_DEFAULT;
      nonce_q <= core_top_pkg::RND_NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = scramble_req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

endmodule

`default_nettype wire

//--- scr_ram_1p.sv
////////////////////////////////////////////////////////////
// Scrambled single-port RAM
// Stores each payload XORed with a keystream built from the
// key, the nonce and the index; one cycle read latency
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module scr_ram_1p #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    key_valid_i,
  input  logic                    req_i,
  input  logic                    write_i,
  input  core_top_pkg::ic_index_t  addr_i,
  input  payload_t                wdata_i,
  input  core_top_pkg::scr_key_t   key_i,
  input  core_top_pkg::scr_nonce_t nonce_i,
  output payload_t                rdata_o
);

  localparam int unsigned PAYLOAD_W = $bits(payload_t);
  localparam int unsigned IDX_EXT_W = core_top_pkg::SCR_KEY_W - core_top_pkg::SCR_NONCE_W;

  logic [IDX_EXT_W-1:0]   index_ext;
  core_top_pkg::scr_key_t ks_word;
  logic [PAYLOAD_W-1:0]   keystream;
  logic                   access;
  payload_t               mem [core_top_pkg::IC_NUM_LINES];
  payload_t               rdata_q;

  ////////////////////////////////////////////////////////////
  // Keystream
  ////////////////////////////////////////////////////////////

  assign index_ext = IDX_EXT_W'(addr_i);
  assign ks_word   = {nonce_i, index_ext} ^ key_i;

  // Word repeated across the payload, first copy in the low bits
  always_comb begin
    for (int unsigned i = 0; i < PAYLOAD_W; i++) begin
      keystream[i] = ks_word[i % core_top_pkg::SCR_KEY_W];
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage and read data
  ////////////////////////////////////////////////////////////

  // Requests without a valid key are dropped
  assign access = req_i & key_valid_i;

  always_ff @(posedge clk_i) begin
    if (access && write_i) begin
      mem[addr_i] <= wdata_i ^ payload_t'(keystream);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (access && !write_i) begin
      rdata_q <= mem[addr_i] ^ payload_t'(keystream);
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- core_top.sv
////////////////////////////////////////////////////////////
// Core infrastructure top level
// Sleep control and clock gate, register file, scramble key
// manager and the scrambled tag and data banks of each way
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_top (
  // Clock, reset and test
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    test_en_i,

  // Sleep control
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_pending_i,
  input  logic                    irq_nm_i,
  output logic                    core_sleep_o,

  // Register file
  input  core_top_pkg::rf_addr_t   rf_raddr_a_i,
  input  core_top_pkg::rf_addr_t   rf_raddr_b_i,
  input  core_top_pkg::rf_addr_t   rf_waddr_i,
  input  core_top_pkg::rf_data_t   rf_wdata_i,
  input  logic                    rf_we_i,
  output core_top_pkg::rf_data_t   rf_rdata_a_o,
  output core_top_pkg::rf_data_t   rf_rdata_b_o,

  // Tag banks
  input  logic [core_top_pkg::IC_NUM_WAYS-1:0] ic_tag_req_i,
  input  logic                    ic_tag_write_i,
  input  core_top_pkg::ic_index_t  ic_tag_addr_i,
  input  core_top_pkg::ic_tag_t    ic_tag_wdata_i,
  output core_top_pkg::ic_tag_t    ic_tag_rdata_o [core_top_pkg::IC_NUM_WAYS],

  // Data banks
  input  logic [core_top_pkg::IC_NUM_WAYS-1:0] ic_data_req_i,
  input  logic                    ic_data_write_i,
  input  core_top_pkg::ic_index_t  ic_data_addr_i,
  input  core_top_pkg::ic_line_t   ic_data_wdata_i,
  output core_top_pkg::ic_line_t   ic_data_rdata_o [core_top_pkg::IC_NUM_WAYS],

  // Key handshake
  input  logic                    icache_inval_i,
  input  logic                    scramble_key_valid_i,
  input  core_top_pkg::scr_key_t   scramble_key_i,
  input  core_top_pkg::scr_nonce_t scramble_nonce_i,
  output logic                    scramble_req_o,
  output logic                    ic_scr_key_valid_o
);

  logic                    clk_gated;
  logic                    key_valid;
  core_top_pkg::scr_key_t   scr_key;
  core_top_pkg::scr_nonce_t scr_nonce;

  ////////////////////////////////////////////////////////////
  // Sleep control and register file
  ////////////////////////////////////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .core_sleep_o (core_sleep_o),
    .clk_gated_o  (clk_gated)
  );

  // Register file only sees gated edges
  register_file_ff u_register_file (
    .clk_i    (clk_gated),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  ////////////////////////////////////////////////////////////
  // Scrambling and cache RAMs
  ////////////////////////////////////////////////////////////

  scramble_key_mgr u_key_mgr (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (key_valid),
    .key_o               (scr_key),
    .nonce_o             (scr_nonce)
  );

  assign ic_scr_key_valid_o = key_valid;

  for (genvar w = 0; w < core_top_pkg::IC_NUM_WAYS; w++) begin : gen_ways
    scr_ram_1p #(
      .payload_t(core_top_pkg::ic_tag_t)
    ) tag_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .key_valid_i(key_valid),
      .req_i      (ic_tag_req_i[w]),
      .write_i    (ic_tag_write_i),
      .addr_i     (ic_tag_addr_i),
      .wdata_i    (ic_tag_wdata_i),
      .key_i      (scr_key),
      .nonce_i    (scr_nonce),
      .rdata_o    (ic_tag_rdata_o[w])
    );

    scr_ram_1p #(
      .payload_t(core_top_pkg::ic_line_t)
    ) data_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .key_valid_i(key_valid),
      .req_i      (ic_data_req_i[w]),
      .write_i    (ic_data_write_i),
      .addr_i     (ic_data_addr_i),
      .wdata_i    (ic_data_wdata_i),
      .key_i      (scr_key),
      .nonce_i    (scr_nonce),
      .rdata_o    (ic_data_rdata_o[w])
    );
  end

endmodule

`default_nettype wire

//--- core_top_chk.sv
////////////////////////////////////////////////////////////
// Assertions on the core infrastructure top level
// Sleep flag, key request handshake and register zero
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_top_chk (
  input wire logic                   clk_i,
  input wire logic                   rst_ni,
  input wire logic                   core_busy_i,
  input wire logic                   debug_req_i,
  input wire logic                   irq_pending_i,
  input wire logic                   irq_nm_i,
  input wire logic                   core_sleep_o,
  input wire logic                   icache_inval_i,
  input wire logic                   scramble_key_valid_i,
  input wire logic                   scramble_req_o,
  input wire core_top_pkg::rf_addr_t rf_raddr_a_i,
  input wire core_top_pkg::rf_data_t rf_rdata_a_o
);

  // Busy acts one edge late
  sleep_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o == !($past(core_busy_i) | debug_req_i | irq_pending_i | irq_nm_i))
    else $error("core_sleep_o does not match the wake terms");

  req_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (icache_inval_i && !scramble_req_o) |=> scramble_req_o)
    else $error("scramble_req_o did not rise after invalidate");

  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scramble_req_o && !scramble_key_valid_i) |=> scramble_req_o)
    else $error("scramble_req_o dropped without a key");

  reg_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rf_raddr_a_i == '0) |-> (rf_rdata_a_o == '0))
    else $error("register zero read as nonzero");

endmodule

bind core_top core_top_chk u_core_top_chk (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .core_busy_i         (core_busy_i),
  .debug_req_i         (debug_req_i),
  .irq_pending_i       (irq_pending_i),
  .irq_nm_i            (irq_nm_i),
  .core_sleep_o        (core_sleep_o),
  .icache_inval_i      (icache_inval_i),
  .scramble_key_valid_i(scramble_key_valid_i),
  .scramble_req_o      (scramble_req_o),
  .rf_raddr_a_i        (rf_raddr_a_i),
  .rf_rdata_a_o        (rf_rdata_a_o)
);

`default_nettype wire

//--- tb_core_top.sv
////////////////////////////////////////////////////////////
// Testbench for the core infrastructure top level
// Directed tests for sleep control, register file, key
// handshake and the scrambled cache RAM banks
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_core_top;

  localparam int unsigned WAIT_LIMIT = 50;
  localparam int unsigned NUM_ENTRIES = 8;

  logic clk_i = 1'b0;
  logic rst_ni, test_en_i, core_busy_i, debug_req_i, irq_pending_i, irq_nm_i;
  logic core_sleep_o, rf_we_i, ic_tag_write_i, ic_data_write_i;
  logic icache_inval_i, scramble_key_valid_i, scramble_req_o, ic_scr_key_valid_o;
  core_top_pkg::rf_addr_t   rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  core_top_pkg::rf_data_t   rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic [core_top_pkg::IC_NUM_WAYS-1:0] ic_tag_req_i, ic_data_req_i;
  core_top_pkg::ic_index_t  ic_tag_addr_i, ic_data_addr_i;
  core_top_pkg::ic_tag_t    ic_tag_wdata_i;
  core_top_pkg::ic_tag_t    ic_tag_rdata_o [core_top_pkg::IC_NUM_WAYS];
  core_top_pkg::ic_line_t   ic_data_wdata_i;
  core_top_pkg::ic_line_t   ic_data_rdata_o [core_top_pkg::IC_NUM_WAYS];
  core_top_pkg::scr_key_t   scramble_key_i, cur_key;
  core_top_pkg::scr_nonce_t scramble_nonce_i, cur_nonce;

  core_top_pkg::rf_data_t rf_model [core_top_pkg::RF_NUM_REGS];
  int unsigned errors = 0;
  int unsigned tests = 0;

  always #2 clk_i = ~clk_i;

  core_top dut (.*);

  // Global limit on simulated time
  initial begin
    #200000;
    $display("Time limit reached before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Next cycle, 1 ns past the rising edge
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic cmp_rf_data(string name, core_top_pkg::rf_data_t got,
                             core_top_pkg::rf_data_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_tag(string name, core_top_pkg::ic_tag_t got, core_top_pkg::ic_tag_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_line(string name, core_top_pkg::ic_line_t got,
                          core_top_pkg::ic_line_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Keystream word: nonce on top, zero-extended index below, XOR key
  function automatic logic [31:0] ks_word(core_top_pkg::scr_key_t key,
                                          core_top_pkg::scr_nonce_t nonce,
                                          core_top_pkg::ic_index_t idx);
    return {nonce, 16'(idx)} ^ key;
  endfunction

  function automatic core_top_pkg::ic_tag_t tag_ks(core_top_pkg::scr_key_t key,
                                                   core_top_pkg::scr_nonce_t nonce,
                                                   core_top_pkg::ic_index_t idx);
    return core_top_pkg::ic_tag_t'(ks_word(key, nonce, idx));
  endfunction

  function automatic core_top_pkg::ic_line_t line_ks(core_top_pkg::scr_key_t key,
                                                     core_top_pkg::scr_nonce_t nonce,
                                                     core_top_pkg::ic_index_t idx);
    return {ks_word(key, nonce, idx), ks_word(key, nonce, idx)};
  endfunction

  task automatic wait_scramble_req(logic lvl);
    int unsigned n;
    n = 0;
    while (scramble_req_o !== lvl && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (scramble_req_o !== lvl) begin
      $display("Timeout waiting for scramble_req_o to reach %b", lvl);
      errors++;
    end
  endtask

  task automatic wait_key_valid(logic lvl);
    int unsigned n;
    n = 0;
    while (ic_scr_key_valid_o !== lvl && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (ic_scr_key_valid_o !== lvl) begin
      $display("Timeout waiting for ic_scr_key_valid_o to reach %b", lvl);
      errors++;
    end
  endtask

  task automatic rf_write(core_top_pkg::rf_addr_t addr, core_top_pkg::rf_data_t data);
    rf_waddr_i = addr;
    rf_wdata_i = data;
    rf_we_i    = 1'b1;
    tick();
    rf_we_i    = 1'b0;
  endtask

  task automatic rf_check(core_top_pkg::rf_addr_t addr, core_top_pkg::rf_data_t exp);
    rf_raddr_a_i = addr;
    rf_raddr_b_i = addr;
    tick();
    cmp_rf_data("rf_rdata_a_o", rf_rdata_a_o, exp);
    cmp_rf_data("rf_rdata_b_o", rf_rdata_b_o, exp);
  endtask

  task automatic ram_write(int way, core_top_pkg::ic_index_t idx,
                           core_top_pkg::ic_tag_t tag, core_top_pkg::ic_line_t line);
    ic_tag_req_i       = '0;
    ic_data_req_i      = '0;
    ic_tag_req_i[way]  = 1'b1;
    ic_data_req_i[way] = 1'b1;
    ic_tag_write_i     = 1'b1;
    ic_data_write_i    = 1'b1;
    ic_tag_addr_i      = idx;
    ic_data_addr_i     = idx;
    ic_tag_wdata_i     = tag;
    ic_data_wdata_i    = line;
    tick();
    ic_tag_req_i       = '0;
    ic_data_req_i      = '0;
    ic_tag_write_i     = 1'b0;
    ic_data_write_i    = 1'b0;
  endtask

  // Read data must be present one edge after the request
  task automatic ram_check(int way, core_top_pkg::ic_index_t idx,
                           core_top_pkg::ic_tag_t tag, core_top_pkg::ic_line_t line);
    ic_tag_req_i[way]  = 1'b1;
    ic_data_req_i[way] = 1'b1;
    ic_tag_addr_i      = idx;
    ic_data_addr_i     = idx;
    tick();
    cmp_tag("ic_tag_rdata_o", ic_tag_rdata_o[way], tag);
    cmp_line("ic_data_rdata_o", ic_data_rdata_o[way], line);
    ic_tag_req_i       = '0;
    ic_data_req_i      = '0;
  endtask

  task automatic pulse_inval();
    icache_inval_i = 1'b1;
    tick();
    icache_inval_i = 1'b0;
  endtask

  task automatic deliver_key(core_top_pkg::scr_key_t key, core_top_pkg::scr_nonce_t nonce);
    scramble_key_valid_i = 1'b1;
    scramble_key_i       = key;
    scramble_nonce_i     = nonce;
    tick();
    scramble_key_valid_i = 1'b0;
    cur_key              = key;
    cur_nonce            = nonce;
  endtask

  task automatic report(string name, int unsigned err_before);
    tests++;
    $display("Test %s: %0d errors", name, errors - err_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_test();
    int unsigned e0;
    e0 = errors;
    tick();
    cmp_bit("core_sleep_o", core_sleep_o, 1'b1);
    cmp_bit("scramble_req_o", scramble_req_o, 1'b0);
    cmp_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b1);
    rf_check('0, '0);
    report("reset", e0);
  endtask

  task automatic rf_test();
    int unsigned e0;
    e0 = errors;
    core_busy_i = 1'b1;
    repeat (2) tick();
    for (int r = 1; r < core_top_pkg::RF_NUM_REGS; r++) begin
      rf_model[r] = $urandom;
      rf_write(core_top_pkg::rf_addr_t'(r), rf_model[r]);
    end
    for (int r = 1; r < core_top_pkg::RF_NUM_REGS; r++) begin
      rf_check(core_top_pkg::rf_addr_t'(r), rf_model[r]);
    end
    rf_write('0, $urandom);
    rf_check('0, '0);
    report("register_file", e0);
  endtask

  task automatic sleep_test();
    int unsigned e0;
    e0 = errors;
    core_busy_i = 1'b0;
    repeat (3) tick();
    cmp_bit("core_sleep_o", core_sleep_o, 1'b1);
    rf_write(5'd5, ~rf_model[5]);
    rf_check(5'd5, rf_model[5]);
    tick();
    // Each wake term on its own
    for (int t = 0; t < 3; t++) begin
      debug_req_i   = (t == 0);
      irq_nm_i      = (t == 1);
      irq_pending_i = (t == 2);
      #1;
      cmp_bit("core_sleep_o", core_sleep_o, 1'b0);
      tick();
      debug_req_i   = 1'b0;
      irq_nm_i      = 1'b0;
      irq_pending_i = 1'b0;
      #1;
      cmp_bit("core_sleep_o", core_sleep_o, 1'b1);
      tick();
    end
    test_en_i   = 1'b1;
    rf_model[5] = $urandom;
    rf_write(5'd5, rf_model[5]);
    cmp_bit("core_sleep_o", core_sleep_o, 1'b1);
    rf_check(5'd5, rf_model[5]);
    test_en_i   = 1'b0;
    report("sleep", e0);
  endtask

  task automatic key_test();
    int unsigned              e0;
    core_top_pkg::ic_tag_t    tag;
    core_top_pkg::ic_line_t   line;
    core_top_pkg::scr_key_t   old_key;
    core_top_pkg::scr_nonce_t old_nonce;
    e0        = errors;
    tag       = core_top_pkg::ic_tag_t'($urandom);
    line      = {$urandom, $urandom};
    old_key   = cur_key;
    old_nonce = cur_nonce;
    ram_write(0, 6'd7, tag, line);
    pulse_inval();
    cmp_bit("scramble_req_o", scramble_req_o, 1'b1);
    cmp_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b0);
    // Ignored while the key is invalid
    ram_write(0, 6'd7, ~tag, ~line);
    repeat (3) tick();
    deliver_key($urandom, 16'($urandom));
    cmp_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b1);
    cmp_bit("scramble_req_o", scramble_req_o, 1'b0);
    ram_check(0, 6'd7,
              tag ^ tag_ks(old_key, old_nonce, 6'd7) ^ tag_ks(cur_key, cur_nonce, 6'd7),
              line ^ line_ks(old_key, old_nonce, 6'd7) ^ line_ks(cur_key, cur_nonce, 6'd7));
    report("key_handshake", e0);
  endtask

  task automatic ram_test();
    int unsigned              e0;
    int                       way [NUM_ENTRIES];
    core_top_pkg::ic_index_t  idx [NUM_ENTRIES];
    core_top_pkg::ic_tag_t    tag [NUM_ENTRIES];
    core_top_pkg::ic_line_t   line [NUM_ENTRIES];
    core_top_pkg::scr_key_t   old_key;
    core_top_pkg::scr_nonce_t old_nonce;
    e0 = errors;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      way[i]  = int'($urandom_range(0, 1));
      idx[i]  = core_top_pkg::ic_index_t'(i * 8 + int'($urandom_range(0, 7)));
      tag[i]  = core_top_pkg::ic_tag_t'($urandom);
      line[i] = {$urandom, $urandom};
      ram_write(way[i], idx[i], tag[i], line[i]);
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      ram_check(way[i], idx[i], tag[i], line[i]);
    end
    old_key   = cur_key;
    old_nonce = cur_nonce;
    pulse_inval();
    wait_scramble_req(1'b1);
    deliver_key($urandom, 16'($urandom));
    wait_key_valid(1'b1);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      ram_check(way[i], idx[i],
                tag[i] ^ tag_ks(old_key, old_nonce, idx[i]) ^
                tag_ks(cur_key, cur_nonce, idx[i]),
                line[i] ^ line_ks(old_key, old_nonce, idx[i]) ^
                line_ks(cur_key, cur_nonce, idx[i]));
    end
    report("scrambled_ram", e0);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hab98));
    rst_ni = 1'b0;
    {test_en_i, core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
    {rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i, rf_wdata_i, rf_we_i} = '0;
    {ic_tag_req_i, ic_tag_write_i, ic_tag_addr_i, ic_tag_wdata_i} = '0;
    {ic_data_req_i, ic_data_write_i, ic_data_addr_i, ic_data_wdata_i} = '0;
    {icache_inval_i, scramble_key_valid_i, scramble_key_i, scramble_nonce_i} = '0;
    cur_key   = core_top_pkg::RND_KEY_DEFAULT;
    cur_nonce = core_top_pkg::RND_NONCE_DEFAULT;
    for (int r = 0; r < core_top_pkg::RF_NUM_REGS; r++) begin
      rf_model[r] = '0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    reset_test();
    rf_test();
    sleep_test();
    key_test();
    ram_test();

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
core_top_pkg.sv
core_sleep_ctrl.sv
register_file_ff.sv
scramble_key_mgr.sv
scr_ram_1p.sv
core_top.sv
core_top_chk.sv
tb_core_top.sv

//--- run.sh
#!/bin/sh
# Build and run the core_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_core_top \
  -Mdir obj_dir \
  -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_core_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
